/* rtl/decode_pkg.sv */
package decode_pkg;

    ////////////////////
    // Field widths
    ////////////////////

    localparam int INSTR_W  = 32;
    localparam int OPCODE_W = 7;
    localparam int SEL_W    = 3;
    localparam int CCU_W    = 8;
    localparam int DMU_W    = 3;
    localparam int JUMP_W   = 4;

    // Three selects, memory width, jump, mode, plus five single bits
    localparam int BUNDLE_W = 3 * SEL_W + DMU_W + JUMP_W + CCU_W + 5;

    typedef logic [INSTR_W-1:0]  instr_t;
    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [SEL_W-1:0]    src_sel_t;
    typedef logic [SEL_W-1:0]    wb_sel_t;
    typedef logic [CCU_W-1:0]    ccu_mode_t;
    typedef logic [DMU_W-1:0]    dmu_mode_t;

    // Branch and jump conditions for the next-pc logic
    typedef enum logic [JUMP_W-1:0] {
        NPC   = 4'h0,    // Sequential pc+4
        OFFPC = 4'h1,    // Unconditional pc+offset
        NEQ   = 4'h2,
        EQ    = 4'h3,
        SLT   = 4'h4,    // Signed less than
        ULT   = 4'h5,    // Unsigned less than
        SGT   = 4'h6,    // Signed greater or equal
        UGT   = 4'h7,    // Unsigned greater or equal
        JALR  = 4'h8     // Register target
    } jump_ctrl_t;

    ////////////////////
    // Major opcodes
    ////////////////////

    localparam opcode_t OP_ARITH_R = 7'b0110011;
    localparam opcode_t OP_ARITH_I = 7'b0010011;
    localparam opcode_t OP_BRANCH  = 7'b1100011;
    localparam opcode_t OP_LOAD    = 7'b0000011;
    localparam opcode_t OP_STORE   = 7'b0100011;
    localparam opcode_t OP_JAL     = 7'b1101111;
    localparam opcode_t OP_JALR    = 7'b1100111;
    localparam opcode_t OP_AUIPC   = 7'b0010111;
    localparam opcode_t OP_LUI     = 7'b0110111;
    localparam opcode_t OP_NONE    = 7'b0000000;   // Bubble

    // funct7 rows of the register arithmetic group
    localparam logic [6:0] F7_BASE   = 7'h00;
    localparam logic [6:0] F7_ALT    = 7'h20;      // sub, sra
    localparam logic [6:0] F7_MULDIV = 7'h01;

    ////////////////////
    // Operand and write-back selects
    ////////////////////

    localparam src_sel_t SRC_REG  = 3'd0;
    localparam src_sel_t SRC_IMM  = 3'd1;
    localparam src_sel_t SRC_PC   = 3'd2;
    localparam src_sel_t SRC_ZERO = 3'd3;

    localparam wb_sel_t WB_EXE = 3'd0;
    localparam wb_sel_t WB_PC4 = 3'd1;
    localparam wb_sel_t WB_MEM = 3'd2;

    ////////////////////
    // Execution modes
    ////////////////////

    // Integer ALU
    localparam ccu_mode_t SUB   = 8'h00;
    localparam ccu_mode_t ADD   = 8'h01;
    localparam ccu_mode_t AND   = 8'h02;
    localparam ccu_mode_t OR    = 8'h03;
    localparam ccu_mode_t XOR   = 8'h04;
    localparam ccu_mode_t RMV   = 8'h05;   // Logic right shift
    localparam ccu_mode_t LMV   = 8'h06;   // Left shift
    localparam ccu_mode_t ARMV  = 8'h07;   // Arithmetic right shift
    localparam ccu_mode_t SLTS  = 8'h08;
    localparam ccu_mode_t SLTUS = 8'h09;

    // Multiply and divide unit
    localparam ccu_mode_t MUL    = 8'h40;
    localparam ccu_mode_t MULH   = 8'h41;
    localparam ccu_mode_t MULHSU = 8'h42;
    localparam ccu_mode_t MULHU  = 8'h43;
    localparam ccu_mode_t DIV    = 8'h44;
    localparam ccu_mode_t DIVU   = 8'h45;
    localparam ccu_mode_t REM    = 8'h46;
    localparam ccu_mode_t REMU   = 8'h47;

    // Data memory access width
    localparam dmu_mode_t BY_WORD   = 3'h0;
    localparam dmu_mode_t BY_HALF   = 3'h1;
    localparam dmu_mode_t BY_HALF_U = 3'h2;
    localparam dmu_mode_t BY_BYTE   = 3'h3;
    localparam dmu_mode_t BY_BYTE_U = 3'h4;

endpackage

/* rtl/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if;

    decode_pkg::src_sel_t   rs1_sel;
    decode_pkg::src_sel_t   rs2_sel;
    decode_pkg::wb_sel_t    wb_sel;
    logic                   rf_we;
    logic                   dm_we;
    logic                   dm_rd;
    decode_pkg::dmu_mode_t  dmu_mode;
    decode_pkg::jump_ctrl_t jump_ctrl;
    decode_pkg::ccu_mode_t  ccu_mode;
    logic                   ccu_ans_sel;
    logic                   illegal;

    // Datapath selects and enables
    modport path_src (
        output rs1_sel, rs2_sel, wb_sel, rf_we, dm_we, dm_rd,
        output dmu_mode, jump_ctrl, illegal
    );

    // Execution unit mode
    modport mode_src (output ccu_mode, ccu_ans_sel);

    modport sink (
        input rs1_sel, rs2_sel, wb_sel, rf_we, dm_we, dm_rd,
        input dmu_mode, jump_ctrl, ccu_mode, ccu_ans_sel, illegal
    );

endinterface

/* rtl/opcode_decoder.sv */
`timescale 1ns/1ps

module opcode_decoder (
    input  decode_pkg::instr_t instr,
    ctrl_if.path_src           ctrl
);

    decode_pkg::opcode_t opcode;
    logic [2:0]          funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb begin
        // Defaults describe a harmless register-register op
        ctrl.rs1_sel   = decode_pkg::SRC_REG;
        ctrl.rs2_sel   = decode_pkg::SRC_REG;
        ctrl.wb_sel    = decode_pkg::WB_EXE;
        ctrl.rf_we     = 1'b0;
        ctrl.dm_we     = 1'b0;
        ctrl.dm_rd     = 1'b0;
        ctrl.dmu_mode  = decode_pkg::BY_WORD;
        ctrl.jump_ctrl = decode_pkg::NPC;
        ctrl.illegal   = 1'b0;

        case (opcode)
            decode_pkg::OP_ARITH_R: begin
                ctrl.rf_we = 1'b1;
            end

            decode_pkg::OP_ARITH_I: begin
                ctrl.rs2_sel = decode_pkg::SRC_IMM;
                ctrl.rf_we   = 1'b1;
            end

            ////////////////////
            // Control flow
            ////////////////////

            decode_pkg::OP_BRANCH: begin
                // Compare done by the ALU as rs1 - rs2
                case (funct3)
                    3'b000:  ctrl.jump_ctrl = decode_pkg::EQ;     // beq
                    3'b001:  ctrl.jump_ctrl = decode_pkg::NEQ;    // bne
                    3'b100:  ctrl.jump_ctrl = decode_pkg::SLT;    // blt
                    3'b101:  ctrl.jump_ctrl = decode_pkg::SGT;    // bge
                    3'b110:  ctrl.jump_ctrl = decode_pkg::ULT;    // bltu
                    3'b111:  ctrl.jump_ctrl = decode_pkg::UGT;    // bgeu
                    default: ctrl.jump_ctrl = decode_pkg::EQ;
                endcase
            end

            decode_pkg::OP_JAL: begin
                ctrl.wb_sel    = decode_pkg::WB_PC4;
                ctrl.rf_we     = 1'b1;
                ctrl.jump_ctrl = decode_pkg::OFFPC;
            end

            decode_pkg::OP_JALR: begin
                ctrl.rs2_sel   = decode_pkg::SRC_IMM;   // Target is rs1 + imm
                ctrl.wb_sel    = decode_pkg::WB_PC4;
                ctrl.rf_we     = 1'b1;
                ctrl.jump_ctrl = decode_pkg::JALR;
            end

            ////////////////////
            // Memory access
            ////////////////////

            decode_pkg::OP_LOAD: begin
                ctrl.rs2_sel = decode_pkg::SRC_IMM;
                ctrl.wb_sel  = decode_pkg::WB_MEM;
                ctrl.rf_we   = 1'b1;
                ctrl.dm_rd   = 1'b1;
                case (funct3)
                    3'b000:  ctrl.dmu_mode = decode_pkg::BY_BYTE;     // lb
                    3'b001:  ctrl.dmu_mode = decode_pkg::BY_HALF;     // lh
                    3'b010:  ctrl.dmu_mode = decode_pkg::BY_WORD;     // lw
                    3'b100:  ctrl.dmu_mode = decode_pkg::BY_BYTE_U;   // lbu
                    3'b101:  ctrl.dmu_mode = decode_pkg::BY_HALF_U;   // lhu
                    default: ctrl.dmu_mode = decode_pkg::BY_WORD;
                endcase
            end

            decode_pkg::OP_STORE: begin
                ctrl.rs2_sel = decode_pkg::SRC_IMM;   // Address is rs1 + imm
                ctrl.dm_we   = 1'b1;
            end

            ////////////////////
            // Upper immediates
            ////////////////////

            decode_pkg::OP_AUIPC: begin
                ctrl.rs1_sel = decode_pkg::SRC_PC;
                ctrl.rs2_sel = decode_pkg::SRC_IMM;
                ctrl.rf_we   = 1'b1;
            end

            decode_pkg::OP_LUI: begin
                ctrl.rs1_sel = decode_pkg::SRC_ZERO;  // 0 + imm
                ctrl.rs2_sel = decode_pkg::SRC_IMM;
                ctrl.rf_we   = 1'b1;
            end

            decode_pkg::OP_NONE: begin
                // Bubble, defaults already keep every enable low
            end

            default: begin
                // Unknown opcode, float and system space included
                ctrl.rs1_sel = decode_pkg::SRC_ZERO;
                ctrl.rs2_sel = decode_pkg::SRC_ZERO;
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

/* rtl/ccu_mode_decoder.sv */
`timescale 1ns/1ps

module ccu_mode_decoder (
    input  decode_pkg::instr_t instr,
    ctrl_if.mode_src           ctrl
);

    decode_pkg::opcode_t opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        ctrl.ccu_mode    = decode_pkg::ADD;   // Address and link arithmetic
        ctrl.ccu_ans_sel = 1'b0;

        case (opcode)
            ////////////////////
            // Register forms
            ////////////////////
            decode_pkg::OP_ARITH_R: begin
                case (funct7)
                    decode_pkg::F7_BASE: begin
                        case (funct3)
                            3'b000: ctrl.ccu_mode = decode_pkg::ADD;
                            3'b001: ctrl.ccu_mode = decode_pkg::LMV;     // sll
                            3'b010: ctrl.ccu_mode = decode_pkg::SLTS;
                            3'b011: ctrl.ccu_mode = decode_pkg::SLTUS;
                            3'b100: ctrl.ccu_mode = decode_pkg::XOR;
                            3'b101: ctrl.ccu_mode = decode_pkg::RMV;     // srl
                            3'b110: ctrl.ccu_mode = decode_pkg::OR;
                            3'b111: ctrl.ccu_mode = decode_pkg::AND;
                        endcase
                    end

                    decode_pkg::F7_ALT: begin
                        case (funct3)
                            3'b000:  ctrl.ccu_mode = decode_pkg::SUB;
                            3'b101:  ctrl.ccu_mode = decode_pkg::ARMV;   // sra
                            default: ctrl.ccu_mode = decode_pkg::ADD;
                        endcase
                    end

                    decode_pkg::F7_MULDIV: begin
                        // Result comes from the multiply/divide unit
                        ctrl.ccu_ans_sel = 1'b1;
                        case (funct3)
                            3'b000: ctrl.ccu_mode = decode_pkg::MUL;
                            3'b001: ctrl.ccu_mode = decode_pkg::MULH;
                            3'b010: ctrl.ccu_mode = decode_pkg::MULHSU;
                            3'b011: ctrl.ccu_mode = decode_pkg::MULHU;
                            3'b100: ctrl.ccu_mode = decode_pkg::DIV;
                            3'b101: ctrl.ccu_mode = decode_pkg::DIVU;
                            3'b110: ctrl.ccu_mode = decode_pkg::REM;
                            3'b111: ctrl.ccu_mode = decode_pkg::REMU;
                        endcase
                    end

                    default: begin
                        ctrl.ccu_mode = decode_pkg::ADD;   // Unsupported row
                    end
                endcase
            end

            ////////////////////
            // Immediate forms
            ////////////////////
            decode_pkg::OP_ARITH_I: begin
                case (funct3)
                    3'b000: ctrl.ccu_mode = decode_pkg::ADD;
                    3'b001: ctrl.ccu_mode = decode_pkg::LMV;     // slli
                    3'b010: ctrl.ccu_mode = decode_pkg::SLTS;
                    3'b011: ctrl.ccu_mode = decode_pkg::SLTUS;
                    3'b100: ctrl.ccu_mode = decode_pkg::XOR;
                    3'b101: begin
                        // Upper bits clear for srli, otherwise srai
                        if (instr[31:26] == 6'b000000) begin
                            ctrl.ccu_mode = decode_pkg::RMV;
                        end else begin
                            ctrl.ccu_mode = decode_pkg::ARMV;
                        end
                    end
                    3'b110: ctrl.ccu_mode = decode_pkg::OR;
                    3'b111: ctrl.ccu_mode = decode_pkg::AND;
                endcase
            end

            decode_pkg::OP_BRANCH: begin
                ctrl.ccu_mode = decode_pkg::SUB;   // Comparison result
            end

            default: begin
                ctrl.ccu_mode = decode_pkg::ADD;
            end
        endcase
    end

endmodule

/* rtl/decode_skid_buffer.sv */
`timescale 1ns/1ps

module decode_skid_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    output logic                   in_ready,
    ctrl_if.sink                   ctrl,
    output logic                   out_valid,
    input  logic                   out_ready,
    output decode_pkg::src_sel_t   rs1_sel,
    output decode_pkg::src_sel_t   rs2_sel,
    output decode_pkg::wb_sel_t    wb_sel,
    output logic                   rf_we,
    output logic                   dm_we,
    output logic                   dm_rd,
    output decode_pkg::dmu_mode_t  dmu_mode,
    output decode_pkg::jump_ctrl_t jump_ctrl,
    output decode_pkg::ccu_mode_t  ccu_mode,
    output logic                   ccu_ans_sel,
    output logic                   illegal
);

    logic [decode_pkg::BUNDLE_W-1:0] in_bundle;
    logic [decode_pkg::BUNDLE_W-1:0] main_q;
    logic [decode_pkg::BUNDLE_W-1:0] skid_q;
    logic                            main_valid;
    logic                            skid_valid;
    logic                            push;
    logic                            pop;

    assign in_bundle = {ctrl.rs1_sel, ctrl.rs2_sel, ctrl.wb_sel, ctrl.rf_we, ctrl.dm_we,
                        ctrl.dm_rd, ctrl.dmu_mode, ctrl.jump_ctrl, ctrl.ccu_mode,
                        ctrl.ccu_ans_sel, ctrl.illegal};

    assign in_ready  = !skid_valid;   // Skid full means both entries full
    assign out_valid = main_valid;
    assign push      = in_valid && in_ready;
    assign pop       = main_valid && out_ready;

    ////////////////////
    // Occupancy
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (skid_valid) begin
            if (pop) begin
                skid_valid <= 1'b0;   // Main refilled from skid, stays valid
            end
        end else if (push) begin
            if (main_valid && !pop) begin
                skid_valid <= 1'b1;   // Main stalled
            end else begin
                main_valid <= 1'b1;
            end
        end else if (pop) begin
            main_valid <= 1'b0;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (skid_valid && pop) begin
            main_q <= skid_q;
        end else if (push && (!main_valid || pop)) begin
            main_q <= in_bundle;
        end
        if (push && main_valid && !pop) begin
            skid_q <= in_bundle;
        end
    end

    assign {rs1_sel, rs2_sel, wb_sel, rf_we, dm_we, dm_rd, dmu_mode} = main_q[28:14];
    assign jump_ctrl = decode_pkg::jump_ctrl_t'(main_q[13:10]);
    assign {ccu_mode, ccu_ans_sel, illegal} = main_q[9:0];

endmodule

/* rtl/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  logic                   clk,
    input  logic                   rst,

    // Instruction stream in
    input  logic                   in_valid,
    output logic                   in_ready,
    input  decode_pkg::instr_t     instr,

    // Control bundle out
    output logic                   out_valid,
    input  logic                   out_ready,
    output decode_pkg::src_sel_t   rs1_sel,
    output decode_pkg::src_sel_t   rs2_sel,
    output decode_pkg::wb_sel_t    wb_sel,
    output logic                   rf_we,
    output logic                   dm_we,
    output logic                   dm_rd,
    output decode_pkg::dmu_mode_t  dmu_mode,
    output decode_pkg::jump_ctrl_t jump_ctrl,
    output decode_pkg::ccu_mode_t  ccu_mode,
    output logic                   ccu_ans_sel,
    output logic                   illegal
);

    ctrl_if ctrl ();   // Decoded bundle, combinational

    opcode_decoder u_opcode_decoder (
        .instr (instr),
        .ctrl  (ctrl.path_src)
    );

    ccu_mode_decoder u_ccu_mode_decoder (
        .instr (instr),
        .ctrl  (ctrl.mode_src)
    );

    ////////////////////
    // Registered output stage
    ////////////////////
    decode_skid_buffer u_buffer (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .ctrl        (ctrl.sink),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .rs1_sel     (rs1_sel),
        .rs2_sel     (rs2_sel),
        .wb_sel      (wb_sel),
        .rf_we       (rf_we),
        .dm_we       (dm_we),
        .dm_rd       (dm_rd),
        .dmu_mode    (dmu_mode),
        .jump_ctrl   (jump_ctrl),
        .ccu_mode    (ccu_mode),
        .ccu_ans_sel (ccu_ans_sel),
        .illegal     (illegal)
    );

endmodule

/* include/decode_vectors.svh */
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// One table row, instruction plus the bundle expected for it
typedef struct packed {
    decode_pkg::instr_t instr;
    logic [8:0]         sels;    // rs1_sel, rs2_sel, wb_sel as octal digits
    logic [2:0]         en;      // rf_we, dm_we, dm_rd
    logic [2:0]         dmu;
    logic [3:0]         jump;
    logic [7:0]         ccu;
    logic [1:0]         flags;   // ccu_ans_sel, illegal
} vector_t;

localparam int NUM_VECTORS = 34;

// Fixed registers rd=3, rs1=1, rs2=2 around the decoded fields
function automatic decode_pkg::instr_t make_instr(input logic [6:0] upper,
                                                  input logic [2:0] funct3,
                                                  input logic [6:0] opcode);
    return {upper, 5'd2, 5'd1, funct3, 5'd3, opcode};
endfunction

// Columns: instr, selects, enables, width, jump, mode, flags
function automatic vector_t vector_row(input int idx);
    vector_t v;
    case (idx)
        // add, sub, sltu, sra, and, then a dropped bit-manip row
        0:  v = '{make_instr(7'h00, 3'd0, 7'h33), 9'o000, 3'b100, 3'd0, 4'h0, 8'h01, 2'b00};
        1:  v = '{make_instr(7'h20, 3'd0, 7'h33), 9'o000, 3'b100, 3'd0, 4'h0, 8'h00, 2'b00};
        2:  v = '{make_instr(7'h00, 3'd3, 7'h33), 9'o000, 3'b100, 3'd0, 4'h0, 8'h09, 2'b00};
        3:  v = '{make_instr(7'h20, 3'd5, 7'h33), 9'o000, 3'b100, 3'd0, 4'h0, 8'h07, 2'b00};
        4:  v = '{make_instr(7'h00, 3'd7, 7'h33), 9'o000, 3'b100, 3'd0, 4'h0, 8'h02, 2'b00};
        5:  v = '{make_instr(7'h05, 3'd4, 7'h33), 9'o000, 3'b100, 3'd0, 4'h0, 8'h01, 2'b00};
        // addi, srli, srai
        6:  v = '{make_instr(7'h00, 3'd0, 7'h13), 9'o010, 3'b100, 3'd0, 4'h0, 8'h01, 2'b00};
        7:  v = '{make_instr(7'h00, 3'd5, 7'h13), 9'o010, 3'b100, 3'd0, 4'h0, 8'h05, 2'b00};
        8:  v = '{make_instr(7'h20, 3'd5, 7'h13), 9'o010, 3'b100, 3'd0, 4'h0, 8'h07, 2'b00};
        // mul through remu
        9:  v = '{make_instr(7'h01, 3'd0, 7'h33), 9'o000, 3'b100, 3'd0, 4'h0, 8'h40, 2'b10};
        10: v = '{make_instr(7'h01, 3'd1, 7'h33), 9'o000, 3'b100, 3'd0, 4'h0, 8'h41, 2'b10};
        11: v = '{make_instr(7'h01, 3'd2, 7'h33), 9'o000, 3'b100, 3'd0, 4'h0, 8'h42, 2'b10};
        12: v = '{make_instr(7'h01, 3'd3, 7'h33), 9'o000, 3'b100, 3'd0, 4'h0, 8'h43, 2'b10};
        13: v = '{make_instr(7'h01, 3'd4, 7'h33), 9'o000, 3'b100, 3'd0, 4'h0, 8'h44, 2'b10};
        14: v = '{make_instr(7'h01, 3'd5, 7'h33), 9'o000, 3'b100, 3'd0, 4'h0, 8'h45, 2'b10};
        15: v = '{make_instr(7'h01, 3'd6, 7'h33), 9'o000, 3'b100, 3'd0, 4'h0, 8'h46, 2'b10};
        16: v = '{make_instr(7'h01, 3'd7, 7'h33), 9'o000, 3'b100, 3'd0, 4'h0, 8'h47, 2'b10};
        // beq, bne, blt, bge, bltu, bgeu, then jal and jalr
        17: v = '{make_instr(7'h00, 3'd0, 7'h63), 9'o000, 3'b000, 3'd0, 4'h3, 8'h00, 2'b00};
        18: v = '{make_instr(7'h00, 3'd1, 7'h63), 9'o000, 3'b000, 3'd0, 4'h2, 8'h00, 2'b00};
        19: v = '{make_instr(7'h00, 3'd4, 7'h63), 9'o000, 3'b000, 3'd0, 4'h4, 8'h00, 2'b00};
        20: v = '{make_instr(7'h00, 3'd5, 7'h63), 9'o000, 3'b000, 3'd0, 4'h6, 8'h00, 2'b00};
        21: v = '{make_instr(7'h00, 3'd6, 7'h63), 9'o000, 3'b000, 3'd0, 4'h5, 8'h00, 2'b00};
        22: v = '{make_instr(7'h00, 3'd7, 7'h63), 9'o000, 3'b000, 3'd0, 4'h7, 8'h00, 2'b00};
        23: v = '{make_instr(7'h00, 3'd0, 7'h6f), 9'o001, 3'b100, 3'd0, 4'h1, 8'h01, 2'b00};
        24: v = '{make_instr(7'h00, 3'd0, 7'h67), 9'o011, 3'b100, 3'd0, 4'h8, 8'h01, 2'b00};
        // lb, lw, lhu, sw
        25: v = '{make_instr(7'h00, 3'd0, 7'h03), 9'o012, 3'b101, 3'd3, 4'h0, 8'h01, 2'b00};
        26: v = '{make_instr(7'h00, 3'd2, 7'h03), 9'o012, 3'b101, 3'd0, 4'h0, 8'h01, 2'b00};
        27: v = '{make_instr(7'h00, 3'd5, 7'h03), 9'o012, 3'b101, 3'd2, 4'h0, 8'h01, 2'b00};
        28: v = '{make_instr(7'h00, 3'd2, 7'h23), 9'o010, 3'b010, 3'd0, 4'h0, 8'h01, 2'b00};
        // lui, auipc, bubble, float add, csrrw
        29: v = '{make_instr(7'h12, 3'd4, 7'h37), 9'o310, 3'b100, 3'd0, 4'h0, 8'h01, 2'b00};
        30: v = '{make_instr(7'h12, 3'd4, 7'h17), 9'o210, 3'b100, 3'd0, 4'h0, 8'h01, 2'b00};
        31: v = '{32'h0000_0000, 9'o000, 3'b000, 3'd0, 4'h0, 8'h01, 2'b00};
        32: v = '{make_instr(7'h00, 3'd0, 7'h53), 9'o330, 3'b000, 3'd0, 4'h0, 8'h01, 2'b01};
        33: v = '{make_instr(7'h00, 3'd1, 7'h73), 9'o330, 3'b000, 3'd0, 4'h0, 8'h01, 2'b01};
        default: v = '0;
    endcase
    return v;
endfunction

`endif

/* test/tb_control_unit.sv */
`timescale 1ns/1ps

module tb_control_unit;

    `include "decode_vectors.svh"

    logic                   clk;
    logic                   rst;
    logic                   in_valid;
    logic                   in_ready;
    decode_pkg::instr_t     instr;
    logic                   out_valid;
    logic                   out_ready;
    decode_pkg::src_sel_t   rs1_sel;
    decode_pkg::src_sel_t   rs2_sel;
    decode_pkg::wb_sel_t    wb_sel;
    logic                   rf_we;
    logic                   dm_we;
    logic                   dm_rd;
    decode_pkg::dmu_mode_t  dmu_mode;
    decode_pkg::jump_ctrl_t jump_ctrl;
    decode_pkg::ccu_mode_t  ccu_mode;
    logic                   ccu_ans_sel;
    logic                   illegal;

    int      errors   = 0;
    int      tests    = 0;
    int      failed   = 0;
    int      received = 0;
    vector_t expected_q[$];   // Accepted rows in arrival order

    control_unit dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_field(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            failed++;
            $display("%s: mismatch", name);
        end
    endtask

    task automatic compare_output(input vector_t v);
        check_field("rs1_sel", 8'(rs1_sel), 8'(v.sels[8:6]));
        check_field("rs2_sel", 8'(rs2_sel), 8'(v.sels[5:3]));
        check_field("wb_sel", 8'(wb_sel), 8'(v.sels[2:0]));
        check_field("rf_we", 8'(rf_we), 8'(v.en[2]));
        check_field("dm_we", 8'(dm_we), 8'(v.en[1]));
        check_field("dm_rd", 8'(dm_rd), 8'(v.en[0]));
        check_field("dmu_mode", 8'(dmu_mode), 8'(v.dmu));
        check_field("jump_ctrl", 8'(jump_ctrl), 8'(v.jump));
        check_field("ccu_mode", ccu_mode, v.ccu);
        check_field("ccu_ans_sel", 8'(ccu_ans_sel), 8'(v.flags[1]));
        check_field("illegal", 8'(illegal), 8'(v.flags[0]));
    endtask

    ////////////////////
    // Stream driver and consumer
    ////////////////////
    task automatic drive_inputs();
        vector_t v;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            while ($urandom_range(3) == 0) begin
                @(negedge clk);   // Idle gap
            end
            v        = vector_row(i);
            in_valid = 1'b1;
            instr    = v.instr;
            while (!in_ready) begin
                @(negedge clk);
            end
            expected_q.push_back(v);   // Taken on the coming edge
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic consume_outputs();
        vector_t v;
        int      errs_before;
        while (received < NUM_VECTORS) begin
            @(negedge clk);
            out_ready = ($urandom_range(3) != 0);
            if (out_valid && out_ready) begin
                errs_before = errors;
                v           = expected_q.pop_front();
                compare_output(v);
                report_test($sformatf("vector %0d (instr %h)", received, v.instr), errs_before);
                received++;
            end
        end
        @(negedge clk);   // Last transfer completes on the edge before
        out_ready = 1'b0;
    endtask

    initial begin
        int errs_before;
        in_valid  = 1'b0;
        instr     = '0;
        out_ready = 1'b0;
        rst       = 1'b1;
        void'($urandom(4165));
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        errs_before = errors;
        check_field("out_valid", 8'(out_valid), 8'd0);
        check_field("in_ready", 8'(in_ready), 8'd1);
        report_test("reset state", errs_before);

        fork
            drive_inputs();
            consume_outputs();
        join

        // Nothing left over and nothing extra on the output
        errs_before = errors;
        check_field("items left", 8'(expected_q.size()), 8'd0);
        @(negedge clk);
        check_field("out_valid", 8'(out_valid), 8'd0);
        report_test("stream order", errs_before);

        $display("Tests: %0d run, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (NUM_VECTORS * 4 + 100) @(posedge clk);
        $display("Timeout: the stream did not finish in %0d cycles", NUM_VECTORS * 4 + 100);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
rtl/decode_pkg.sv
rtl/ctrl_if.sv
rtl/opcode_decoder.sv
rtl/ccu_mode_decoder.sv
rtl/decode_skid_buffer.sv
rtl/control_unit.sv
test/tb_control_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_control_unit -f verilog.f \
    || { echo "Verilator build failed"; exit 1; }

sim_output="$(./obj_dir/Vtb_control_unit)"
echo "${sim_output}"
echo "${sim_output}" | grep -q "Simulation PASSED" && exit 0 || exit 1
